//--- Bender.yml
package:
  name: mpu_subsys

sources:
  # Design sources in compile order
  - files:
      - common/mpu_pkg.sv
      - mpu/mpu_pma.sv
      - mpu/mpu_pmp.sv
      - mpu/mpu.sv
      - src/txn_tracker.sv
      - src/mpu_subsys.sv

  # Testbench
  - target: test
    files:
      - verif/tb_mpu_subsys.sv

//--- common/mpu_pkg.sv
// Shared MPU types; 32-bit physical addresses only, fixed three-entry PMA table, no debug region
`default_nettype none

package mpu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Basic types
  //////////////////////////////////////////////////////////////////////

  // Byte address on core and bus side
  typedef logic [31:0] addr_t;

  // Only user and machine mode exist on this path
  typedef enum logic {
    PRIV_U = 1'b0,
    PRIV_M = 1'b1
  } priv_e;

  // Status returned to the core with each response
  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RE_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

  // Error FSM states
  typedef enum logic [2:0] {
    MPU_IDLE        = 3'd0,
    MPU_RE_ERR_WAIT = 3'd1,
    MPU_WR_ERR_WAIT = 3'd2,
    MPU_RE_ERR_RESP = 3'd3,
    MPU_WR_ERR_RESP = 3'd4
  } mpu_state_e;

  //////////////////////////////////////////////////////////////////////
  // PMP
  //////////////////////////////////////////////////////////////////////

  // Address matching mode, same encoding as the pmpcfg A field
  typedef enum logic [1:0] {
    PMP_OFF   = 2'b00,
    PMP_TOR   = 2'b01,
    PMP_NA4   = 2'b10,
    PMP_NAPOT = 2'b11
  } pmp_mode_e;

  // Access kind; no fetch on the data side
  typedef enum logic [1:0] {
    PMP_ACC_WRITE = 2'b01,
    PMP_ACC_READ  = 2'b10
  } pmp_req_e;

  // One region configuration, 6 bits
  typedef struct packed {
    logic      lock;
    pmp_mode_e mode;
    logic      x;
    logic      w;
    logic      r;
  } pmp_cfg_t;

  //////////////////////////////////////////////////////////////////////
  // PMA
  //////////////////////////////////////////////////////////////////////

  // Inclusive start and end bounds
  typedef struct packed {
    addr_t start_addr;
    addr_t end_addr;
    logic  main;
    logic  read_only;
    logic  bufferable;
    logic  cacheable;
  } pma_region_t;

  localparam int PMA_NUM_REGIONS = 3;

  // ROM, RAM and IO; everything else is unmapped
  localparam pma_region_t PMA_TABLE [PMA_NUM_REGIONS] = '{
    '{start_addr: 32'h0000_0000, end_addr: 32'h0000_FFFF,
      main: 1'b1, read_only: 1'b1, bufferable: 1'b0, cacheable: 1'b1},
    '{start_addr: 32'h1000_0000, end_addr: 32'h1000_FFFF,
      main: 1'b1, read_only: 1'b0, bufferable: 1'b1, cacheable: 1'b1},
    '{start_addr: 32'h2000_0000, end_addr: 32'h2000_0FFF,
      main: 1'b0, read_only: 1'b0, bufferable: 1'b0, cacheable: 1'b0}
  };

endpackage

`default_nettype wire

//--- mpu/mpu.sv
// Data-side MPU; faults always answered in order after drain, core must always accept responses
`default_nettype none

module mpu #(
  parameter int PMP_NUM_REGIONS = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // Core request
  input  logic                 core_req_valid_i,
  input  mpu_pkg::addr_t       core_req_addr_i,
  input  logic                 core_req_we_i,
  input  mpu_pkg::priv_e       core_req_priv_i,
  output logic                 core_req_ready_o,

  // Core response
  output logic                 core_rsp_valid_o,
  output mpu_pkg::mpu_status_e core_rsp_status_o,
  output logic                 core_rsp_bus_err_o,

  // Bus request
  output logic                 bus_req_valid_o,
  output mpu_pkg::addr_t       bus_req_addr_o,
  output logic                 bus_req_we_o,
  output logic [1:0]           bus_req_memtype_o,
  input  logic                 bus_req_ready_i,

  // Bus response
  input  logic                 bus_rsp_valid_i,
  input  logic                 bus_rsp_err_i,

  // PMP configuration
  input  logic                 csr_we_i,
  input  logic [3:0]           csr_idx_i,
  input  mpu_pkg::pmp_cfg_t    csr_cfg_i,
  input  mpu_pkg::addr_t       csr_addr_i,

  // From the transaction tracker
  input  logic                 one_txn_pend_n_i,
  input  logic                 full_i,

  output logic                 mpu_err_o
);

  import mpu_pkg::*;

  logic        pma_err;
  logic        pmp_err;
  logic        mpu_err;
  logic        pma_bufferable;
  logic        pma_cacheable;
  logic        mpu_block_core;
  logic        mpu_block_bus;
  logic        err_rsp_valid;
  logic        err_req_ready;
  mpu_status_e mpu_status;
  mpu_state_e  state_q;
  mpu_state_e  state_n;
  pmp_req_e    pmp_req_type;

  //////////////////////////////////////////////////////////////////////
  // Error FSM
  //////////////////////////////////////////////////////////////////////

  // A failing request is swallowed, then the FSM waits until it is the
  // only one left in flight and answers it in its place in the order
  always_comb begin
    state_n        = state_q;
    mpu_status     = MPU_OK;
    // Tracker full stalls every accept
    mpu_block_core = full_i;
    mpu_block_bus  = full_i;
    err_rsp_valid  = 1'b0;
    err_req_ready  = 1'b0;

    case (state_q)
      MPU_IDLE: begin
        if (core_req_valid_i && mpu_err) begin
          // Never let a faulting request out
          mpu_block_bus = 1'b1;
          if (!full_i) begin
            err_req_ready = 1'b1;
            if (core_req_we_i) begin
              state_n = one_txn_pend_n_i ? MPU_WR_ERR_RESP : MPU_WR_ERR_WAIT;
            end else begin
              state_n = one_txn_pend_n_i ? MPU_RE_ERR_RESP : MPU_RE_ERR_WAIT;
            end
          end
        end
      end
      MPU_RE_ERR_WAIT, MPU_WR_ERR_WAIT: begin
        // Earlier bus transactions still draining
        mpu_block_core = 1'b1;
        mpu_block_bus  = 1'b1;
        if (one_txn_pend_n_i) begin
          state_n = (state_q == MPU_RE_ERR_WAIT) ? MPU_RE_ERR_RESP : MPU_WR_ERR_RESP;
        end
      end
      MPU_RE_ERR_RESP, MPU_WR_ERR_RESP: begin
        mpu_block_core = 1'b1;
        mpu_block_bus  = 1'b1;
        err_rsp_valid  = 1'b1;
        mpu_status     = (state_q == MPU_RE_ERR_RESP) ? MPU_RE_FAULT : MPU_WR_FAULT;
        // Single cycle, the core takes it unconditionally
        state_n        = MPU_IDLE;
      end
      default: state_n = MPU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MPU_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Request and response paths
  //////////////////////////////////////////////////////////////////////

  assign bus_req_valid_o   = core_req_valid_i && !mpu_block_bus;
  assign bus_req_addr_o    = core_req_addr_i;
  assign bus_req_we_o      = core_req_we_i;
  // Bit 0 bufferable, bit 1 cacheable
  assign bus_req_memtype_o = {pma_cacheable, pma_bufferable};

  assign core_req_ready_o  = (bus_req_ready_i && !mpu_block_core) || err_req_ready;

  // Bus and fault responses never overlap
  assign core_rsp_valid_o   = bus_rsp_valid_i || err_rsp_valid;
  assign core_rsp_status_o  = mpu_status;
  assign core_rsp_bus_err_o = bus_rsp_valid_i && bus_rsp_err_i;

  assign mpu_err   = pma_err || pmp_err;
  assign mpu_err_o = mpu_err;

  //////////////////////////////////////////////////////////////////////
  // Checkers
  //////////////////////////////////////////////////////////////////////

  assign pmp_req_type = core_req_we_i ? PMP_ACC_WRITE : PMP_ACC_READ;

  mpu_pma u_pma (
    .addr_i           (core_req_addr_i),
    .we_i             (core_req_we_i),
    .pma_err_o        (pma_err),
    .pma_bufferable_o (pma_bufferable),
    .pma_cacheable_o  (pma_cacheable)
  );

  mpu_pmp #(
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS)
  ) u_pmp (
    .clk        (clk),
    .rst_n      (rst_n),
    .csr_we_i   (csr_we_i),
    .csr_idx_i  (csr_idx_i),
    .csr_cfg_i  (csr_cfg_i),
    .csr_addr_i (csr_addr_i),
    .req_addr_i (core_req_addr_i),
    .req_type_i (pmp_req_type),
    .priv_i     (core_req_priv_i),
    .pmp_err_o  (pmp_err)
  );

endmodule

`default_nettype wire

//--- mpu/mpu_pma.sv
// Fixed-table PMA lookup; purely combinational, first matching region wins, no misaligned handling
`default_nettype none

module mpu_pma (
  input  mpu_pkg::addr_t addr_i,
  input  logic           we_i,
  output logic           pma_err_o,
  output logic           pma_bufferable_o,
  output logic           pma_cacheable_o
);

  import mpu_pkg::*;

  // Set once a region has claimed the address
  logic matched;

  //////////////////////////////////////////////////////////////////////
  // Region search
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Unmapped until proven otherwise
    matched          = 1'b0;
    pma_err_o        = 1'b1;
    pma_bufferable_o = 1'b0;
    pma_cacheable_o  = 1'b0;

    for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
      // Lower index takes priority over overlapping later entries
      if (!matched &&
          (addr_i >= PMA_TABLE[i].start_addr) &&
          (addr_i <= PMA_TABLE[i].end_addr)) begin
        matched = 1'b1;

        if (we_i && PMA_TABLE[i].read_only) begin
          // Store to ROM
          pma_err_o        = 1'b1;
          pma_bufferable_o = 1'b0;
          pma_cacheable_o  = 1'b0;
        end else begin
          // Attributes only carried on a clean hit
          pma_err_o        = 1'b0;
          pma_bufferable_o = PMA_TABLE[i].bufferable;
          pma_cacheable_o  = PMA_TABLE[i].cacheable;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- mpu/mpu_pmp.sv
// PMP with 1 to 16 regions; 32-bit addresses only, no granularity, exec bit stored but never checked
`default_nettype none

module mpu_pmp #(
  parameter int PMP_NUM_REGIONS = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              csr_we_i,
  input  logic [3:0]        csr_idx_i,
  input  mpu_pkg::pmp_cfg_t csr_cfg_i,
  input  mpu_pkg::addr_t    csr_addr_i,
  input  mpu_pkg::addr_t    req_addr_i,
  input  mpu_pkg::pmp_req_e req_type_i,
  input  mpu_pkg::priv_e    priv_i,
  output logic              pmp_err_o
);

  import mpu_pkg::*;

  // Region state, addresses held in word units
  pmp_cfg_t                   cfg_q  [PMP_NUM_REGIONS];
  addr_t                      addr_q [PMP_NUM_REGIONS];
  addr_t                      word_addr;
  logic [PMP_NUM_REGIONS-1:0] region_match;
  logic                       found;

  // NAPOT mask from the trailing ones of a region address
  // Word bit 0 is always ignored, so the smallest region is 8 bytes
  function automatic addr_t napot_mask_f(addr_t a);
    addr_t mask;
    logic  run;
    mask = '0;
    run  = 1'b1;
    for (int j = 1; j < 32; j++) begin
      run     = run & a[j-1];
      mask[j] = ~run;
    end
    return mask;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // CSR write port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
        cfg_q[i]  <= '0;
        addr_q[i] <= '0;
      end
    end else if (csr_we_i) begin
      // Out of range index never hits; locked regions keep their value
      for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
        if ((csr_idx_i == 4'(i)) && !cfg_q[i].lock) begin
          cfg_q[i]  <= csr_cfg_i;
          addr_q[i] <= csr_addr_i;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Per-region address match
  //////////////////////////////////////////////////////////////////////

  assign word_addr = {2'b00, req_addr_i[31:2]};

  for (genvar g = 0; g < PMP_NUM_REGIONS; g++) begin : gen_match
    addr_t tor_base;
    addr_t napot_mask;

    // Region 0 TOR starts at zero
    if (g == 0) begin : gen_base_zero
      assign tor_base = '0;
    end else begin : gen_base_prev
      assign tor_base = addr_q[g-1];
    end

    assign napot_mask = napot_mask_f(addr_q[g]);

    always_comb begin
      case (cfg_q[g].mode)
        PMP_TOR:   region_match[g] = (word_addr >= tor_base) && (word_addr < addr_q[g]);
        PMP_NA4:   region_match[g] = (word_addr == addr_q[g]);
        PMP_NAPOT: region_match[g] = ((word_addr & napot_mask) == (addr_q[g] & napot_mask));
        default:   region_match[g] = 1'b0;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Priority and permission
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // No match: only machine mode gets through
    found     = 1'b0;
    pmp_err_o = (priv_i == PRIV_U);

    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      if (!found && region_match[i]) begin
        found = 1'b1;
        if ((priv_i == PRIV_M) && !cfg_q[i].lock) begin
          // Unlocked regions do not constrain M mode
          pmp_err_o = 1'b0;
        end else if (req_type_i == PMP_ACC_WRITE) begin
          pmp_err_o = !cfg_q[i].w;
        end else begin
          pmp_err_o = !cfg_q[i].r;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- mpu_subsys.f
common/mpu_pkg.sv
mpu/mpu_pma.sv
mpu/mpu_pmp.sv
mpu/mpu.sv
src/txn_tracker.sv
src/mpu_subsys.sv
verif/tb_mpu_subsys.sv

//--- src/mpu_subsys.sv
// MPU subsystem top; bus responses must come back in order, core always ready for responses
`default_nettype none

module mpu_subsys #(
  parameter int PMP_NUM_REGIONS = 4,
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 core_req_valid_i,
  input  mpu_pkg::addr_t       core_req_addr_i,
  input  logic                 core_req_we_i,
  input  mpu_pkg::priv_e       core_req_priv_i,
  output logic                 core_req_ready_o,

  output logic                 core_rsp_valid_o,
  output mpu_pkg::mpu_status_e core_rsp_status_o,
  output logic                 core_rsp_bus_err_o,

  output logic                 bus_req_valid_o,
  output mpu_pkg::addr_t       bus_req_addr_o,
  output logic                 bus_req_we_o,
  output logic [1:0]           bus_req_memtype_o,
  input  logic                 bus_req_ready_i,

  input  logic                 bus_rsp_valid_i,
  input  logic                 bus_rsp_err_i,

  input  logic                 csr_we_i,
  input  logic [3:0]           csr_idx_i,
  input  mpu_pkg::pmp_cfg_t    csr_cfg_i,
  input  mpu_pkg::addr_t       csr_addr_i,

  output logic                 mpu_err_o
);

  logic accept;
  logic one_txn_pend_n;
  logic full;

  // Faulting requests count too, they are answered by the MPU
  assign accept = core_req_valid_i && core_req_ready_o;

  txn_tracker #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_txn_tracker (
    .clk              (clk),
    .rst_n            (rst_n),
    .accept_i         (accept),
    .resp_i           (core_rsp_valid_o),
    .one_txn_pend_n_o (one_txn_pend_n),
    .full_o           (full)
  );

  mpu #(
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS)
  ) u_mpu (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_req_valid_i   (core_req_valid_i),
    .core_req_addr_i    (core_req_addr_i),
    .core_req_we_i      (core_req_we_i),
    .core_req_priv_i    (core_req_priv_i),
    .core_req_ready_o   (core_req_ready_o),
    .core_rsp_valid_o   (core_rsp_valid_o),
    .core_rsp_status_o  (core_rsp_status_o),
    .core_rsp_bus_err_o (core_rsp_bus_err_o),
    .bus_req_valid_o    (bus_req_valid_o),
    .bus_req_addr_o     (bus_req_addr_o),
    .bus_req_we_o       (bus_req_we_o),
    .bus_req_memtype_o  (bus_req_memtype_o),
    .bus_req_ready_i    (bus_req_ready_i),
    .bus_rsp_valid_i    (bus_rsp_valid_i),
    .bus_rsp_err_i      (bus_rsp_err_i),
    .csr_we_i           (csr_we_i),
    .csr_idx_i          (csr_idx_i),
    .csr_cfg_i          (csr_cfg_i),
    .csr_addr_i         (csr_addr_i),
    .one_txn_pend_n_i   (one_txn_pend_n),
    .full_i             (full),
    .mpu_err_o          (mpu_err_o)
  );

endmodule

`default_nettype wire

//--- src/txn_tracker.sv
// Outstanding transaction counter; count saturates at 0 and MAX_OUTSTANDING, full stalls accepts
`default_nettype none

module txn_tracker #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic accept_i,
  input  logic resp_i,
  output logic one_txn_pend_n_o,
  output logic full_o
);

  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_n;

  // Next count, simultaneous accept and response cancel out
  always_comb begin
    cnt_n = cnt_q;
    if (accept_i && !resp_i && (cnt_q != CNT_W'(MAX_OUTSTANDING))) begin
      cnt_n = cnt_q + 1'b1;
    end else if (resp_i && !accept_i && (cnt_q != '0)) begin
      cnt_n = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_n;
    end
  end

  // Looks one cycle ahead for the error FSM
  assign one_txn_pend_n_o = (cnt_n == CNT_W'(1));
  assign full_o           = (cnt_q == CNT_W'(MAX_OUTSTANDING));

endmodule

`default_nettype wire

//--- verif/mpu_patterns.txt
# C idx cfg(lock,mode,x,w,r) pmpaddr(word units)
# A addr we priv(0 U,1 M) status(0 ok,1 rd fault,2 wr fault) memtype(cache,buf) bus_err
A 10000000 0 1 0 3 0
A 10000004 1 1 0 3 1
A 00000100 0 1 0 2 0
A 20000010 1 1 0 0 0
A 30000000 0 1 1 0 0
A 00000200 1 1 2 0 0
A 00010000 0 1 1 0 0
A 10000000 0 0 1 0 0
C 0 19 040001FF
A 10000000 0 0 0 3 0
A 10000FFC 0 0 0 3 1
A 10000010 1 0 2 0 0
A 10001000 0 0 1 0 0
C 1 00 04000400
C 2 0B 04000800
A 10001000 1 0 0 3 0
A 10001FFC 0 0 0 3 0
A 10002000 0 0 1 0 0
C 3 13 08000040
A 20000100 1 0 0 0 0
A 20000103 0 0 0 0 0
A 20000104 0 0 1 0 0
A 10000020 1 1 0 3 0
C 0 39 040001FF
A 10000020 1 1 2 0 0
A 10000020 0 1 0 3 0
C 0 1B 040001FF
A 10000024 1 1 2 0 0
A 10000100 0 1 0 3 0
A 10000104 0 1 0 3 1
A 10000108 0 0 0 3 0
A 30000000 1 0 2 0 0
A 10000200 0 1 0 3 0
A 0000FFFC 0 1 0 2 1

//--- verif/tb_mpu_subsys.sv
// MPU subsystem testbench; reads verif/mpu_patterns.txt from the project root and the bus model answers in order
`default_nettype none

module tb_mpu_subsys;

  import mpu_pkg::*;

  localparam int    HALF_PERIOD = 20;
  localparam int    DRV_DLY     = 2;
  localparam int    MAX_PAT     = 64;
  localparam int    CYC_PER_PAT = 20;
  localparam string PAT_FILE    = "verif/mpu_patterns.txt";

  logic        clk;
  logic        rst_n;
  logic        core_req_valid_i;
  addr_t       core_req_addr_i;
  logic        core_req_we_i;
  priv_e       core_req_priv_i;
  logic        core_req_ready_o;
  logic        core_rsp_valid_o;
  mpu_status_e core_rsp_status_o;
  logic        core_rsp_bus_err_o;
  logic        bus_req_valid_o;
  addr_t       bus_req_addr_o;
  logic        bus_req_we_o;
  logic [1:0]  bus_req_memtype_o;
  logic        bus_req_ready_i;
  logic        bus_rsp_valid_i;
  logic        bus_rsp_err_i;
  logic        csr_we_i;
  logic [3:0]  csr_idx_i;
  pmp_cfg_t    csr_cfg_i;
  addr_t       csr_addr_i;
  logic        mpu_err_o;

  // Pattern table with one entry per file line
  logic [7:0]  pat_kind [MAX_PAT];
  logic [31:0] pat_addr [MAX_PAT];
  logic [3:0]  pat_idx  [MAX_PAT];
  logic [5:0]  pat_cfg  [MAX_PAT];
  logic        pat_we   [MAX_PAT];
  logic        pat_priv [MAX_PAT];
  logic [1:0]  pat_st   [MAX_PAT];
  logic [1:0]  pat_mt   [MAX_PAT];
  logic        pat_berr [MAX_PAT];
  logic        pat_bad  [MAX_PAT];
  int          n_pat;

  // Expected responses in issue order
  int          exp_idx_q  [$];
  logic [1:0]  exp_st_q   [$];
  logic        exp_berr_q [$];
  // Bus errors still owed by the responder
  logic        rsp_err_q  [$];

  logic [31:0] lfsr_q;
  logic        cur_berr;
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;
  int          wd_cycles;

  mpu_subsys #(
    .PMP_NUM_REGIONS (4),
    .MAX_OUTSTANDING (4)
  ) UUT (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_req_valid_i   (core_req_valid_i),
    .core_req_addr_i    (core_req_addr_i),
    .core_req_we_i      (core_req_we_i),
    .core_req_priv_i    (core_req_priv_i),
    .core_req_ready_o   (core_req_ready_o),
    .core_rsp_valid_o   (core_rsp_valid_o),
    .core_rsp_status_o  (core_rsp_status_o),
    .core_rsp_bus_err_o (core_rsp_bus_err_o),
    .bus_req_valid_o    (bus_req_valid_o),
    .bus_req_addr_o     (bus_req_addr_o),
    .bus_req_we_o       (bus_req_we_o),
    .bus_req_memtype_o  (bus_req_memtype_o),
    .bus_req_ready_i    (bus_req_ready_i),
    .bus_rsp_valid_i    (bus_rsp_valid_i),
    .bus_rsp_err_i      (bus_rsp_err_i),
    .csr_we_i           (csr_we_i),
    .csr_idx_i          (csr_idx_i),
    .csr_cfg_i          (csr_cfg_i),
    .csr_addr_i         (csr_addr_i),
    .mpu_err_o          (mpu_err_o)
  );

  always #HALF_PERIOD clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [3:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v      = {v[2:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Reference region map from the PMA table as {fault, cacheable, bufferable}
  function automatic logic [2:0] ref_pma(input logic [31:0] a, input logic we);
    if (a <= 32'h0000_FFFF) return we ? 3'b100 : 3'b010;
    if ((a >= 32'h1000_0000) && (a <= 32'h1000_FFFF)) return 3'b011;
    if ((a >= 32'h2000_0000) && (a <= 32'h2000_0FFF)) return 3'b000;
    return 3'b100;
  endfunction

  task automatic note_error(input int i);
    err_cnt++;
    pat_bad[i] = 1'b1;
  endtask

  task automatic report_pattern(input int i);
    if (pat_bad[i]) fail_cnt++;
    else pass_cnt++;
    $display("Pattern %0d addr %h we %0d priv %0d: %s", i, pat_addr[i], pat_we[i],
             pat_priv[i], pat_bad[i] ? "fail" : "pass");
  endtask

  // Expected line must agree with the region map before it is trusted
  task automatic cross_check_line(input int i);
    logic [2:0] r;
    logic [1:0] flt;
    r   = ref_pma(pat_addr[i], pat_we[i]);
    flt = pat_we[i] ? 2'd2 : 2'd1;
    assert ((pat_st[i] == 2'd0) ? (!r[2] && (r[1:0] == pat_mt[i])) : (pat_st[i] == flt))
      else begin
        $display("Pattern %0d does not agree with the reference PMA table", i);
        note_error(i);
      end
  endtask

  task automatic load_patterns(output logic ok);
    int          fd;
    int          n;
    string       line;
    logic [7:0]  ch;
    logic [31:0] f1, f2, f3, f4, f5, f6;
    ok    = 1'b1;
    n_pat = 0;
    fd    = $fopen(PAT_FILE, "r");
    if (fd == 0) begin
      ok = 1'b0;
    end else begin
      while (!$feof(fd) && ok) begin
        line = "";
        ch   = 8'h00;
        n    = $fgets(line, fd);
        if (n > 0) n = $sscanf(line, "%c", ch);
        if ((ch == "C") || (ch == "A")) begin
          if (n_pat >= MAX_PAT) ok = 1'b0;
          if (ch == "C") n = $sscanf(line, "%c %h %h %h", ch, f1, f2, f3);
          else n = $sscanf(line, "%c %h %h %h %h %h %h", ch, f1, f2, f3, f4, f5, f6);
          if (n != ((ch == "C") ? 4 : 7)) ok = 1'b0;
          if (ok) begin
            pat_kind[n_pat] = ch;
            pat_bad[n_pat]  = 1'b0;
            // CSR line holds index, cfg and word address
            pat_idx[n_pat]  = f1[3:0];
            pat_cfg[n_pat]  = f2[5:0];
            pat_addr[n_pat] = (ch == "C") ? f3 : f1;
            // Access line holds addr, we, priv, status, memtype and bus error
            pat_we[n_pat]   = f2[0];
            pat_priv[n_pat] = f3[0];
            pat_st[n_pat]   = f4[1:0];
            pat_mt[n_pat]   = f5[1:0];
            pat_berr[n_pat] = f6[0];
            n_pat++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////////////////////////

  task automatic write_pmp_csr(input int i);
    core_req_valid_i = 1'b0;
    csr_we_i         = 1'b1;
    csr_idx_i        = pat_idx[i];
    csr_cfg_i        = pmp_cfg_t'(pat_cfg[i]);
    csr_addr_i       = pat_addr[i];
    @(posedge clk);
    #DRV_DLY;
    csr_we_i = 1'b0;
    pass_cnt++;
    $display("Pattern %0d csr write region %0d cfg %h addr %h: pass", i, pat_idx[i],
             pat_cfg[i], pat_addr[i]);
  endtask

  // Hold the request until the DUT takes it and check both sides each cycle
  task automatic drive_access(input int i);
    logic seen;
    seen = 1'b0;
    cross_check_line(i);
    cur_berr         = pat_berr[i];
    core_req_valid_i = 1'b1;
    core_req_addr_i  = pat_addr[i];
    core_req_we_i    = pat_we[i];
    core_req_priv_i  = priv_e'(pat_priv[i]);
    while (!seen) begin
      @(negedge clk);
      assert (mpu_err_o == (pat_st[i] != 2'd0))
        else begin
          $display("FAILED mpu_err_o pattern %0d: got %h expected %h", i, mpu_err_o,
                   pat_st[i] != 2'd0);
          note_error(i);
        end
      if (bus_req_valid_o) begin
        assert (pat_st[i] == 2'd0)
          else begin
            $display("Pattern %0d: a faulting request was issued on the bus", i);
            note_error(i);
          end
        assert (bus_req_addr_o == pat_addr[i])
          else begin
            $display("FAILED bus_req_addr_o pattern %0d: got %h expected %h", i,
                     bus_req_addr_o, pat_addr[i]);
            note_error(i);
          end
        assert (bus_req_we_o == pat_we[i])
          else begin
            $display("FAILED bus_req_we_o pattern %0d: got %h expected %h", i,
                     bus_req_we_o, pat_we[i]);
            note_error(i);
          end
        assert (bus_req_memtype_o == pat_mt[i])
          else begin
            $display("FAILED bus_req_memtype_o pattern %0d: got %h expected %h", i,
                     bus_req_memtype_o, pat_mt[i]);
            note_error(i);
          end
      end
      seen = core_req_ready_o;
      if (seen) begin
        // On accept a passing request sits on the bus and a faulting one does not
        assert (bus_req_valid_o == (pat_st[i] == 2'd0))
          else begin
            $display("FAILED bus_req_valid_o pattern %0d: got %h expected %h", i,
                     bus_req_valid_o, pat_st[i] == 2'd0);
            note_error(i);
          end
      end
      @(posedge clk);
      if (seen) begin
        exp_idx_q.push_back(i);
        exp_st_q.push_back(pat_st[i]);
        // Faults never carry a bus error
        exp_berr_q.push_back((pat_st[i] == 2'd0) ? pat_berr[i] : 1'b0);
      end
      #DRV_DLY;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus responder
  //////////////////////////////////////////////////////////////////////

  // Random ready and in-order responses 1 to 4 cycles after the handshake
  initial begin : bus_responder
    logic       hs;
    logic       hs_err;
    logic       armed;
    logic       nxt_valid;
    logic       nxt_err;
    logic [3:0] r;
    int         wait_cnt;
    lfsr_q          = 32'h4256;
    bus_req_ready_i = 1'b0;
    bus_rsp_valid_i = 1'b0;
    bus_rsp_err_i   = 1'b0;
    armed           = 1'b0;
    wait_cnt        = 0;
    forever begin
      @(negedge clk);
      hs     = bus_req_valid_o && bus_req_ready_i;
      hs_err = cur_berr;
      @(posedge clk);
      #DRV_DLY;
      if (hs) rsp_err_q.push_back(hs_err);
      nxt_valid = 1'b0;
      nxt_err   = 1'b0;
      if (!armed && (rsp_err_q.size() != 0)) begin
        rand_bits(2, r);
        wait_cnt = r;
        armed    = 1'b1;
      end
      if (armed) begin
        if (wait_cnt == 0) begin
          nxt_valid = 1'b1;
          nxt_err   = rsp_err_q.pop_front();
          armed     = 1'b0;
        end else begin
          wait_cnt--;
        end
      end
      // Ready three cycles out of four on average
      rand_bits(2, r);
      bus_req_ready_i = |r[1:0];
      bus_rsp_valid_i = nxt_valid;
      bus_rsp_err_i   = nxt_err;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Scoreboard and watchdog
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : scoreboard
    int         idx;
    logic [1:0] st;
    logic       be;
    if (rst_n && core_rsp_valid_o) begin
      assert (exp_idx_q.size() != 0)
        else begin
          $display("A core response arrived with no request outstanding");
          err_cnt++;
        end
      if (exp_idx_q.size() != 0) begin
        idx = exp_idx_q.pop_front();
        st  = exp_st_q.pop_front();
        be  = exp_berr_q.pop_front();
        assert (core_rsp_status_o == st)
          else begin
            $display("FAILED core_rsp_status_o pattern %0d: got %h expected %h", idx,
                     core_rsp_status_o, st);
            note_error(idx);
          end
        assert (core_rsp_bus_err_o == be)
          else begin
            $display("FAILED core_rsp_bus_err_o pattern %0d: got %h expected %h", idx,
                     core_rsp_bus_err_o, be);
            note_error(idx);
          end
        report_pattern(idx);
      end
    end
  end

  initial begin : watchdog
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", wd_cycles);
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    logic ok;
    clk              = 1'b0;
    rst_n            = 1'b0;
    core_req_valid_i = 1'b0;
    core_req_addr_i  = '0;
    core_req_we_i    = 1'b0;
    core_req_priv_i  = PRIV_M;
    csr_we_i         = 1'b0;
    csr_idx_i        = '0;
    csr_cfg_i        = '0;
    csr_addr_i       = '0;
    cur_berr         = 1'b0;
    err_cnt          = 0;
    pass_cnt         = 0;
    fail_cnt         = 0;
    wd_cycles        = 0;
    load_patterns(ok);
    if (!ok || (n_pat == 0)) begin
      $display("Could not read a valid pattern list from %s", PAT_FILE);
      $display("Simulation FAILED");
      $finish;
    end else begin
      wd_cycles = (n_pat * CYC_PER_PAT) + 3;
      repeat (3) @(posedge clk);
      #DRV_DLY;
      rst_n = 1'b1;
      @(posedge clk);
      #DRV_DLY;
      for (int i = 0; i < n_pat; i++) begin
        if (pat_kind[i] == "C") write_pmp_csr(i);
        else drive_access(i);
      end
      core_req_valid_i = 1'b0;
      // Drain and then a few idle cycles to catch stray responses
      while (exp_idx_q.size() != 0) @(posedge clk);
      repeat (4) @(posedge clk);
      $display("Summary: %0d patterns, %0d passed, %0d failed, %0d check errors", n_pat,
               pass_cnt, fail_cnt, err_cnt);
      if ((err_cnt == 0) && (fail_cnt == 0) && (pass_cnt == n_pat)) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire
